//--- src.f
verilog/axi_rd_pkg.sv
verilog/axi_rd_fsm.sv
verilog/axi_rd_burst_counter.sv
verilog/axi_rd_align.sv
verilog/axi_rd_top.sv
tb/axi_rd_mem_slave.sv
tb/tb_axi_rd.sv

//--- tb/axi_rd_mem_slave.sv
`timescale 1ns/10ps

module axi_rd_mem_slave (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        stall_ar_i,
   input  logic        stall_r_i,
   input  logic [31:0] araddr_i,
   input  logic [7:0]  arlen_i,
   input  logic        arvalid_i,
   output logic        arready_o,
   output logic [31:0] rdata_o,
   output logic        rvalid_o,
   output logic        rlast_o,
   input  logic        rready_i,
   output int          burst_count_o,
   output int          error_count_o
);

   logic        ar_hs;
   logic        r_hs;
   logic [31:0] ar_addr_q;
   logic [7:0]  ar_len_q;
   logic [31:0] addr;
   int          beats_left;   // Beats of the open burst
   int          errs;

   // Byte at A is A[7:0] ^ A[15:8] ^ 5A
   function automatic logic [31:0] mem_word(logic [31:0] a);
      logic [31:0] w;
      logic [31:0] b;
      for (int j = 0; j < 4; j++) begin
         b = a + 32'(j);
         w[j*8 +: 8] = b[7:0] ^ b[15:8] ^ 8'h5A;
      end
      return w;
   endfunction

   initial begin
      arready_o     = 1'b0;
      rvalid_o      = 1'b0;
      rlast_o       = 1'b0;
      rdata_o       = '0;
      addr          = '0;
      burst_count_o = 0;
      error_count_o = 0;
      errs          = 0;
   end

   // Handshakes as the DUT sees them on the rising edge
   always @(posedge clk_i) begin
      ar_hs <= !rst_i && arvalid_i && arready_o;
      r_hs  <= !rst_i && rvalid_o && rready_i;
      if (arvalid_i && arready_o) begin
         ar_addr_q <= araddr_i;
         ar_len_q  <= arlen_i;
      end
   end

   always @(negedge clk_i) begin
      if (rst_i) begin
         beats_left = 0;
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         rlast_o   <= 1'b0;
      end else begin
         if (r_hs) begin
            addr       = addr + 32'd4;
            beats_left = beats_left - 1;
         end
         if (ar_hs) begin
            if (ar_len_q > 8'd15) begin
               $display("Burst at %h has %0d beats, more than 16",
                        ar_addr_q, int'(ar_len_q) + 1);
               errs++;
            end
            if (int'(ar_addr_q[11:0]) + (int'(ar_len_q) + 1) * 4 > 4096) begin
               $display("Burst at %h of %0d beats crosses a 4 KB boundary",
                        ar_addr_q, int'(ar_len_q) + 1);
               errs++;
            end
            addr          = ar_addr_q;
            beats_left    = int'(ar_len_q) + 1;
            burst_count_o <= burst_count_o + 1;
         end
         arready_o     <= (beats_left == 0) && !stall_ar_i;
         rvalid_o      <= (beats_left != 0) && (!stall_r_i || (rvalid_o && !r_hs));
         rdata_o       <= mem_word(addr);
         rlast_o       <= (beats_left == 1);
         error_count_o <= errs;
      end
   end

endmodule

//--- tb/tb_axi_rd.sv
`timescale 1ns/10ps

module tb_axi_rd;

   import axi_rd_pkg::*;

   localparam int TIMEOUT = 3000;   // Cycles per wait

   logic                  clk;
   logic                  rst;
   logic                  req_valid;
   logic [AXI_ADDR_W-1:0] req_addr;
   logic [LEN_W-1:0]      req_len;
   logic                  req_ready;
   logic [AXI_DATA_W-1:0] rd_data;
   logic                  rd_valid;
   logic                  rd_last;
   logic [AXI_ADDR_W-1:0] araddr;
   logic [AXI_LEN_W-1:0]  arlen;
   logic [2:0]            arsize;
   logic [1:0]            arburst;
   logic [3:0]            arcache;
   logic [2:0]            arprot;
   logic                  arid;
   logic                  arvalid;
   logic                  arready;
   logic [AXI_DATA_W-1:0] rdata;
   logic                  rvalid;
   logic                  rlast;
   logic                  rready;
   logic                  stall_en;
   logic                  stall_ar;
   logic                  stall_r;
   logic [15:0]           lfsr_q;
   int                    burst_count;
   int                    slave_errors;
   int                    slave_seen;
   int                    errors;
   int                    mark;      // Error count at the start of a test
   int                    tests;
   int                    failed_tests;

   axi_rd_top dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .req_valid_i   (req_valid),
      .req_addr_i    (req_addr),
      .req_len_i     (req_len),
      .req_ready_o   (req_ready),
      .rd_data_o     (rd_data),
      .rd_valid_o    (rd_valid),
      .rd_last_o     (rd_last),
      .axi_araddr_o  (araddr),
      .axi_arlen_o   (arlen),
      .axi_arsize_o  (arsize),
      .axi_arburst_o (arburst),
      .axi_arcache_o (arcache),
      .axi_arprot_o  (arprot),
      .axi_arid_o    (arid),
      .axi_arvalid_o (arvalid),
      .axi_arready_i (arready),
      .axi_rdata_i   (rdata),
      .axi_rvalid_i  (rvalid),
      .axi_rlast_i   (rlast),
      .axi_rready_o  (rready)
   );

   axi_rd_mem_slave u_mem (
      .clk_i         (clk),
      .rst_i         (rst),
      .stall_ar_i    (stall_ar),
      .stall_r_i     (stall_r),
      .araddr_i      (araddr),
      .arlen_i       (arlen),
      .arvalid_i     (arvalid),
      .arready_o     (arready),
      .rdata_o       (rdata),
      .rvalid_o      (rvalid),
      .rlast_o       (rlast),
      .rready_i      (rready),
      .burst_count_o (burst_count),
      .error_count_o (slave_errors)
   );

   always #2 clk = ~clk;

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
         lfsr_q = lfsr_q ^ 16'hB400;
      end
      return b;
   endfunction

   always @(negedge clk) begin
      if (stall_en) begin
         stall_ar <= lfsr_bit();
         stall_r  <= lfsr_bit();
      end else begin
         stall_ar <= 1'b0;
         stall_r  <= 1'b0;
      end
   end

   function automatic logic [7:0] mem_byte(logic [31:0] a);
      return a[7:0] ^ a[15:8] ^ 8'h5A;
   endfunction

   // Word k carries request bytes 4k..4k+3, zero past the length
   function automatic logic [31:0] expected_word(logic [31:0] addr, int len, int k);
      logic [31:0] w;
      int          n;
      w = '0;
      for (int j = 0; j < 4; j++) begin
         n = 4 * k + j;
         if (n < len) begin
            w[j*8 +: 8] = mem_byte(addr + 32'(n));
         end
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout while %s", what);
      $display("TESTS FAILED");
      $finish;
   endtask

   // Called on a falling edge, returns on the falling edge that shows rd_last
   task automatic run_request(input logic [31:0] addr, input int len);
      int   cycles;
      int   idx;
      logic done;
      idx       = 0;
      done      = 1'b0;
      cycles    = 0;
      req_valid = 1'b1;
      req_addr  = addr;
      req_len   = LEN_W'(len);
      while (!req_ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_on_timeout("waiting for req_ready_o");
      end
      @(negedge clk);
      req_valid = 1'b0;
      cycles    = 0;
      while (!done) begin
         if (rd_valid) begin
            check_value("rd_data_o", rd_data, expected_word(addr, len, idx));
            idx++;
         end
         if (rd_last) begin
            check_value("rd_valid_o", rd_valid, 1);
            check_value("word count", idx, (len + 3) / 4);
            done = 1'b1;
         end else begin
            check_value("req_ready_o", req_ready, 0);   // Busy until the last word
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) abort_on_timeout("waiting for rd_last_o");
         end
      end
   endtask

   task automatic end_test(input string name);
      errors     += slave_errors - slave_seen;
      slave_seen  = slave_errors;
      tests++;
      if (errors == mark) begin
         $display("Test %s: pass", name);
      end else begin
         failed_tests++;
         $display("Test %s: %0d errors", name, errors - mark);
      end
      mark = errors;
   endtask

   task automatic outputs_after_reset();
      check_value("req_ready_o", req_ready, 1);
      check_value("axi_arvalid_o", arvalid, 0);
      check_value("axi_rready_o", rready, 0);
      check_value("rd_valid_o", rd_valid, 0);
      check_value("rd_last_o", rd_last, 0);
      check_value("axi_arsize_o", arsize, 3'h2);     // 4-byte beats
      check_value("axi_arburst_o", arburst, 2'h1);   // INCR
      check_value("axi_arcache_o", arcache, 4'h2);   // Normal non-cacheable
      check_value("axi_arprot_o", arprot, 3'h2);     // Unprivileged non-secure data
      check_value("axi_arid_o", arid, 0);
      end_test("reset state and AR ties");
   endtask

   task automatic aligned_read();
      run_request(32'h0000_0100, 16);
      end_test("aligned 16 bytes");
   endtask

   task automatic unaligned_reads();
      run_request(32'h0000_0201, 7);
      run_request(32'h0000_0302, 13);
      run_request(32'h0000_0403, 5);
      run_request(32'h0000_0481, 1);
      end_test("unaligned offsets");
   endtask

   task automatic multi_burst_read();
      int b0;
      b0 = burst_count;
      run_request(32'h0000_1100, 200);
      check_value("burst count", burst_count - b0, 4);   // 50 beats as 16+16+16+2
      end_test("multi burst");
   endtask

   task automatic page_split_read();
      int b0;
      b0 = burst_count;
      run_request(32'h0000_2FFA, 20);
      check_value("burst count", burst_count - b0, 2);   // 2 beats, then 4 from 0x3000
      end_test("page split");
   endtask

   task automatic stalled_reads();
      stall_en = 1'b1;
      run_request(32'h0000_0523, 37);
      run_request(32'h0000_0FF1, 70);
      run_request(32'h0000_1000, 64);
      stall_en = 1'b0;
      end_test("random stalls");
   endtask

   task automatic back_to_back_reads();
      run_request(32'h0000_0600, 24);
      run_request(32'h0000_0713, 9);
      end_test("back to back");
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      req_valid    = 1'b0;
      req_addr     = '0;
      req_len      = '0;
      stall_en     = 1'b0;
      stall_ar     = 1'b0;
      stall_r      = 1'b0;
      lfsr_q       = 16'd51041;
      slave_seen   = 0;
      errors       = 0;
      mark         = 0;
      tests        = 0;
      failed_tests = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      outputs_after_reset();
      aligned_read();
      unaligned_reads();
      multi_burst_read();
      page_split_read();
      stalled_reads();
      back_to_back_reads();
      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/axi_rd_align.sv
`timescale 1ns/10ps

module axi_rd_align (
   input  logic                              clk_i,
   input  logic                              rst_i,

   input  logic                              xfer_start_i,
   input  logic [axi_rd_pkg::OFFSET_W-1:0]   offset_i,
   input  logic [axi_rd_pkg::LEN_W-1:0]      len_i,

   input  logic                              beat_i,
   input  logic                              beat_last_burst_i,
   input  logic [axi_rd_pkg::AXI_DATA_W-1:0] rdata_i,

   output logic [axi_rd_pkg::AXI_DATA_W-1:0] rd_data_o,
   output logic                              rd_valid_o,
   output logic                              rd_last_o,
   output logic                              empty_o
);

   import axi_rd_pkg::*;

   logic [OFFSET_W-1:0]     offset_q;
   logic [LEN_W-1:0]        words_q;    // Client words still to emit
   logic [LEN_W-1:0]        bytes_q;    // Request bytes not yet emitted
   logic                    first_q;
   logic                    flush_q;
   logic                    rd_valid_q;
   logic                    rd_last_q;
   logic [AXI_DATA_W-1:0]   prev_q;
   logic [AXI_DATA_W-1:0]   rd_data_q;

   logic [LEN_W:0]          len_round;
   logic                    emit_beat;
   logic                    emit_flush;
   logic                    emit;
   logic [AXI_DATA_W-1:0]   hi_word;
   logic [2*AXI_DATA_W-1:0] joined;
   logic [AXI_DATA_W-1:0]   word;

   assign len_round = {1'b0, len_i} + (LEN_W+1)'((1 << OFFSET_W) - 1);

   // With an offset the first beat holds only part of word 0
   assign emit_beat  = beat_i && (words_q != '0) && !(first_q && (offset_q != '0));
   assign emit_flush = flush_q && (words_q != '0);   // Tail bytes of the last beat
   assign emit       = emit_beat || emit_flush;

   assign hi_word = emit_flush ? '0 : rdata_i;
   assign joined  = {hi_word, prev_q} >> {offset_q, 3'b000};

   always_comb begin
      word = (offset_q == '0) ? rdata_i : joined[AXI_DATA_W-1:0];
      for (int b = 0; b < AXI_DATA_W / 8; b++) begin
         if (LEN_W'(b) >= bytes_q) begin
            word[b*8 +: 8] = 8'h00;   // Past the requested length
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         offset_q   <= '0;
         words_q    <= '0;
         bytes_q    <= '0;
         first_q    <= 1'b0;
         flush_q    <= 1'b0;
         rd_valid_q <= 1'b0;
         rd_last_q  <= 1'b0;
      end else begin
         rd_valid_q <= emit;
         rd_last_q  <= emit && (words_q == LEN_W'(1));
         flush_q    <= beat_i && beat_last_burst_i;
         if (beat_i) begin
            first_q <= 1'b0;
         end
         if (xfer_start_i) begin
            offset_q <= offset_i;
            words_q  <= LEN_W'(len_round[LEN_W:OFFSET_W]);
            bytes_q  <= len_i;
            first_q  <= 1'b1;
         end else if (emit) begin
            words_q <= words_q - LEN_W'(1);
            if (bytes_q > LEN_W'(AXI_DATA_W / 8)) begin
               bytes_q <= bytes_q - LEN_W'(AXI_DATA_W / 8);
            end else begin
               bytes_q <= '0;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (beat_i) begin
         prev_q <= rdata_i;
      end
      if (emit) begin
         rd_data_q <= word;
      end
   end

   assign rd_data_o  = rd_data_q;
   assign rd_valid_o = rd_valid_q;
   assign rd_last_o  = rd_last_q;
   assign empty_o    = (words_q == '0);

   // Stream stays quiet after its last word until a new request starts
   a_no_word_after_last: assert property (
      @(posedge clk_i) disable iff (rst_i)
      rd_last_o && !xfer_start_i |=> (!rd_valid_o until xfer_start_i)
   );

endmodule

//--- verilog/axi_rd_burst_counter.sv
`timescale 1ns/10ps

module axi_rd_burst_counter (
   input  logic                              clk_i,
   input  logic                              rst_i,

   input  logic [axi_rd_pkg::AXI_ADDR_W-1:0] req_addr_i,
   input  logic [axi_rd_pkg::LEN_W-1:0]      req_len_i,

   input  logic                              xfer_start_i,
   input  logic                              load_len_i,
   input  logic                              burst_start_i,

   output logic [axi_rd_pkg::AXI_ADDR_W-1:0] araddr_o,
   output logic [axi_rd_pkg::AXI_LEN_W-1:0]  arlen_o,
   output logic                              last_burst_o
);

   import axi_rd_pkg::*;

   logic [AXI_ADDR_W-1:0] addr_q;      // Word aligned burst address
   logic [LEN_W-1:0]      remain_q;    // Beats still to request
   logic [AXI_LEN_W-1:0]  arlen_q;
   logic                  last_q;

   logic [LEN_W:0]        span;
   logic [LEN_W-1:0]      total_beats;
   logic [LEN_W-1:0]      page_words;
   logic [LEN_W-1:0]      burst_beats;
   logic [LEN_W-1:0]      burst_words;
   logic [PAGE_W:0]       burst_end;

   // ceil((offset + len) / 4)
   assign span = (LEN_W+1)'(req_addr_i[OFFSET_W-1:0]) + (LEN_W+1)'(req_len_i)
               + (LEN_W+1)'((1 << OFFSET_W) - 1);
   assign total_beats = LEN_W'(span[LEN_W:OFFSET_W]);

   // Words left before the next page boundary
   assign page_words = LEN_W'(1 << (PAGE_W - OFFSET_W))
                     - LEN_W'(addr_q[PAGE_W-1:OFFSET_W]);

   always_comb begin
      burst_beats = remain_q;
      if (burst_beats > LEN_W'(MAX_BEATS)) begin
         burst_beats = LEN_W'(MAX_BEATS);
      end
      if (burst_beats > page_words) begin
         burst_beats = page_words;
      end
   end

   assign burst_words = LEN_W'(arlen_q) + LEN_W'(1);
   assign burst_end   = {1'b0, addr_q[PAGE_W-1:0]} + (PAGE_W+1)'(burst_words << OFFSET_W);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         addr_q   <= '0;
         remain_q <= '0;
         arlen_q  <= '0;
         last_q   <= 1'b0;
      end else begin
         if (xfer_start_i) begin
            addr_q   <= {req_addr_i[AXI_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            remain_q <= total_beats;
         end else if (load_len_i) begin
            arlen_q <= AXI_LEN_W'(burst_beats - LEN_W'(1));
            last_q  <= (burst_beats == remain_q);   // Covers everything left
         end else if (burst_start_i) begin
            addr_q   <= addr_q + (AXI_ADDR_W'(burst_words) << OFFSET_W);
            remain_q <= remain_q - burst_words;
         end
      end
   end

   assign araddr_o     = addr_q;
   assign arlen_o      = arlen_q;
   assign last_burst_o = last_q;

   // Each issued burst stays within 16 beats and inside one 4 KB page
   a_burst_legal: assert property (
      @(posedge clk_i) disable iff (rst_i)
      burst_start_i |-> (arlen_o < AXI_LEN_W'(MAX_BEATS))
                        && (burst_end <= (PAGE_W+1)'(1 << PAGE_W))
   );

endmodule

//--- verilog/axi_rd_fsm.sv
`timescale 1ns/10ps

module axi_rd_fsm (
   input  logic clk_i,
   input  logic rst_i,

   input  logic req_valid_i,
   input  logic align_empty_i,
   input  logic arready_i,
   input  logic rvalid_i,
   input  logic rlast_i,
   input  logic last_burst_i,

   output logic req_ready_o,
   output logic arvalid_o,
   output logic rready_o,
   output logic xfer_start_o,
   output logic burst_start_o,
   output logic load_len_o
);

   import axi_rd_pkg::*;

   rd_state_e state_q;
   logic      arvalid_q;
   logic      rlast_hs;

   // New request only once the aligner has drained the previous stream
   assign req_ready_o   = (state_q == ST_IDLE) && align_empty_i;
   assign xfer_start_o  = req_ready_o && req_valid_i;
   assign load_len_o    = (state_q == ST_PLAN);
   assign arvalid_o     = arvalid_q;
   assign burst_start_o = arvalid_q && arready_i;   // AR handshake
   assign rready_o      = (state_q == ST_DATA);
   assign rlast_hs      = rvalid_i && rready_o && rlast_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= ST_IDLE;
         arvalid_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (xfer_start_o) begin
                  state_q <= ST_PLAN;
               end
            end
            ST_PLAN: begin   // Counter registers the burst length here
               arvalid_q <= 1'b1;
               state_q   <= ST_ADDR;
            end
            ST_ADDR: begin
               if (arready_i) begin
                  arvalid_q <= 1'b0;
                  state_q   <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (rlast_hs) begin
                  state_q <= last_burst_i ? ST_IDLE : ST_PLAN;
               end
            end
            default: begin
               state_q   <= ST_IDLE;
               arvalid_q <= 1'b0;
            end
         endcase
      end
   end

   // AXI rule, the address must be held until the slave takes it
   a_arvalid_hold: assert property (
      @(posedge clk_i) disable iff (rst_i)
      arvalid_o && !arready_i |=> arvalid_o
   );

   // Data phase is entered only through an AR handshake
   a_rready_after_ar: assert property (
      @(posedge clk_i) disable iff (rst_i)
      $rose(rready_o) |-> $past(arvalid_o && arready_i) && !arvalid_o
   );

endmodule

//--- verilog/axi_rd_pkg.sv
package axi_rd_pkg;

   // Bus and request widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int OFFSET_W   = 2;    // Byte lanes in a word
   localparam int AXI_LEN_W  = 8;
   localparam int LEN_W      = 12;   // Request length in bytes, up to 4095

   // Burst limits
   localparam int MAX_BEATS = 16;
   localparam int PAGE_W    = 12;    // 4 KB page

   // Constant AR channel fields
   localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;   // 4 bytes per beat
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [3:0] AXI_CACHE_DEF  = 4'h2;     // Normal non-cacheable
   localparam logic [2:0] AXI_PROT_DEF   = 3'b010;

   // Request sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PLAN,
      ST_ADDR,
      ST_DATA
   } rd_state_e;

endpackage

//--- verilog/axi_rd_top.sv
`timescale 1ns/10ps

module axi_rd_top (
   input  logic                              clk_i,
   input  logic                              rst_i,

   input  logic                              req_valid_i,
   input  logic [axi_rd_pkg::AXI_ADDR_W-1:0] req_addr_i,
   input  logic [axi_rd_pkg::LEN_W-1:0]      req_len_i,
   output logic                              req_ready_o,

   output logic [axi_rd_pkg::AXI_DATA_W-1:0] rd_data_o,
   output logic                              rd_valid_o,
   output logic                              rd_last_o,

   output logic [axi_rd_pkg::AXI_ADDR_W-1:0] axi_araddr_o,
   output logic [axi_rd_pkg::AXI_LEN_W-1:0]  axi_arlen_o,
   output logic [2:0]                        axi_arsize_o,
   output logic [1:0]                        axi_arburst_o,
   output logic [3:0]                        axi_arcache_o,
   output logic [2:0]                        axi_arprot_o,
   output logic                              axi_arid_o,
   output logic                              axi_arvalid_o,
   input  logic                              axi_arready_i,

   input  logic [axi_rd_pkg::AXI_DATA_W-1:0] axi_rdata_i,
   input  logic                              axi_rvalid_i,
   input  logic                              axi_rlast_i,
   output logic                              axi_rready_o
);

   import axi_rd_pkg::*;

   logic xfer_start;
   logic burst_start;
   logic load_len;
   logic last_burst;
   logic align_empty;
   logic beat;
   logic beat_last_burst;

   assign axi_arsize_o  = AXI_SIZE_WORD;
   assign axi_arburst_o = AXI_BURST_INCR;
   assign axi_arcache_o = AXI_CACHE_DEF;
   assign axi_arprot_o  = AXI_PROT_DEF;
   assign axi_arid_o    = 1'b0;   // Single ID, in-order only

   assign beat            = axi_rvalid_i && axi_rready_o;
   assign beat_last_burst = axi_rlast_i && last_burst;

   axi_rd_fsm u_fsm (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_valid_i   (req_valid_i),
      .align_empty_i (align_empty),
      .arready_i     (axi_arready_i),
      .rvalid_i      (axi_rvalid_i),
      .rlast_i       (axi_rlast_i),
      .last_burst_i  (last_burst),
      .req_ready_o   (req_ready_o),
      .arvalid_o     (axi_arvalid_o),
      .rready_o      (axi_rready_o),
      .xfer_start_o  (xfer_start),
      .burst_start_o (burst_start),
      .load_len_o    (load_len)
   );

   axi_rd_burst_counter u_counter (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_addr_i    (req_addr_i),
      .req_len_i     (req_len_i),
      .xfer_start_i  (xfer_start),
      .load_len_i    (load_len),
      .burst_start_i (burst_start),
      .araddr_o      (axi_araddr_o),
      .arlen_o       (axi_arlen_o),
      .last_burst_o  (last_burst)
   );

   axi_rd_align u_align (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .xfer_start_i      (xfer_start),
      .offset_i          (req_addr_i[OFFSET_W-1:0]),
      .len_i             (req_len_i),
      .beat_i            (beat),
      .beat_last_burst_i (beat_last_burst),
      .rdata_i           (axi_rdata_i),
      .rd_data_o         (rd_data_o),
      .rd_valid_o        (rd_valid_o),
      .rd_last_o         (rd_last_o),
      .empty_o           (align_empty)
   );

endmodule
